//--- src.f
logic/fifo_types_pkg.sv
logic/fifo_cfg_pkg.sv
logic/fifo_ptr_if.sv
logic/fifo_wr_ptr.sv
logic/fifo_rd_ptr.sv
logic/gray_sync.sv
logic/fifo_mem.sv
logic/fifo_control.sv
logic/fifo_async.sv
tests/tb_clk_gen.sv
tests/fifo_async_assertions.sv
tests/fifo_async_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the async FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=fifo_async_sim
log_file=sim.log

verilator --binary --timing --assert \
        -f src.f \
        --top-module fifo_async_tb \
        --Mdir "$build_dir" \
        -o "$sim_bin"
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

# Error limit raised so the testbench can report and stop by itself
"./$build_dir/$sim_bin" +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
        echo "Simulation exited with status $sim_status"
        exit 1
fi

if grep -qx "Done: no errors" "$log_file"; then
        echo "Simulation passed"
        exit 0
fi
echo "Simulation failed"
exit 1

//--- tests/fifo_async_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_async_tb
        import fifo_types_pkg::*, fifo_cfg_pkg::*;
();

        localparam int rd_period = 100;
        localparam int wr_period = 130;
        localparam int reset_cycles = 10;
        // Roughly three times the rd_clk cycles of all phases together
        localparam int timeout_cycles = 6000;
        // Idle edges per domain before flags and count are final
        localparam int idle_need = 6;

        logic  rd_clk;
        logic  wr_clk;
        logic  wr_rst_n;
        logic  rd_rst_n;
        logic  wr_en;
        logic  rd_en;
        data_t wr_data;
        data_t rd_data;
        ptr_t  count;
        logic  wr_full;
        logic  wr_almost_full;
        logic  rd_empty;
        logic  rd_almost_empty;

        // ----------------------------------------
        // Reference model
        // ----------------------------------------

        // Every accepted word in order of arrival
        // Read side walks it by index
        data_t sent_q[$];
        int    push_total = 0;
        int    pop_total = 0;
        int    model_size;
        data_t model_front;
        logic  no_write_yet;
        int    wr_idle = 0;
        int    rd_idle = 0;
        logic  settled;
        int    cycle_cnt = 0;

        assign model_size   = push_total - pop_total;
        assign model_front  = (model_size > 0) ? sent_q[pop_total] : '0;
        assign no_write_yet = (push_total == 0);
        assign settled      = (wr_idle >= idle_need) && (rd_idle >= idle_need);

        tb_clk_gen #(.period_ns(rd_period)) u_rd_clk (.clk(rd_clk));
        tb_clk_gen #(.period_ns(wr_period)) u_wr_clk (.clk(wr_clk));

        fifo_async uut (
                .wr_clk          (wr_clk),
                .wr_rst_n        (wr_rst_n),
                .wr_en           (wr_en),
                .wr_data         (wr_data),
                .rd_clk          (rd_clk),
                .rd_rst_n        (rd_rst_n),
                .rd_en           (rd_en),
                .rd_data         (rd_data),
                .count           (count),
                .wr_full         (wr_full),
                .wr_almost_full  (wr_almost_full),
                .rd_empty        (rd_empty),
                .rd_almost_empty (rd_almost_empty)
        );

        bind fifo_async fifo_async_assertions u_chk (
                .wr_clk          (wr_clk),
                .wr_rst_n        (wr_rst_n),
                .rd_clk          (rd_clk),
                .rd_rst_n        (rd_rst_n),
                .rd_en           (rd_en),
                .rd_data         (rd_data),
                .count           (count),
                .wr_full         (wr_full),
                .wr_almost_full  (wr_almost_full),
                .rd_empty        (rd_empty),
                .rd_almost_empty (rd_almost_empty),
                .model_front     (fifo_async_tb.model_front),
                .model_size      (fifo_async_tb.model_size),
                .no_write_yet    (fifo_async_tb.no_write_yet),
                .settled         (fifo_async_tb.settled)
        );

        // Write accepted when the pre-edge full flag is low
        always @(posedge wr_clk) begin
                if (wr_rst_n && wr_en && !wr_full) begin
                        sent_q.push_back(wr_data);
                        push_total++;
                end
                if (wr_en) begin
                        wr_idle = 0;
                end else if (wr_idle < idle_need) begin
                        wr_idle++;
                end
        end

        // Accepted read retires the head
        always @(posedge rd_clk) begin
                if (rd_rst_n && rd_en && !rd_empty) begin
                        pop_total++;
                end
                if (rd_en) begin
                        rd_idle = 0;
                end else if (rd_idle < idle_need) begin
                        rd_idle++;
                end
        end

        // Watchdog and assertion monitor
        always @(posedge rd_clk) begin
                cycle_cnt++;
                if (uut.u_chk.err_count != 0) begin
                        fail_run("Assertion failure reported, stopping");
                end else if (cycle_cnt >= timeout_cycles) begin
                        fail_run("Timeout, the test phases did not complete");
                end
        end

        // ----------------------------------------
        // Tasks
        // ----------------------------------------
        task automatic fail_run(input string why);
                $display("%s", why);
                $display("Done: errors found");
                $fatal(1, "Simulation stopped");
        endtask

        task automatic apply_reset();
                repeat (reset_cycles) @(negedge rd_clk);
                rd_rst_n = 1'b1;
                @(negedge wr_clk);
                wr_rst_n = 1'b1;
        endtask

        // Both domains quiet
        task automatic settle(input int n);
                @(negedge wr_clk);
                wr_en = 1'b0;
                @(negedge rd_clk);
                rd_en = 1'b0;
                repeat (n) @(negedge wr_clk);
        endtask

        // Strobes whether or not the FIFO is full
        task automatic write_strobes(input int n);
                repeat (n) begin
                        @(negedge wr_clk);
                        wr_en = 1'b1;
                        wr_data = data_t'($urandom);
                end
                @(negedge wr_clk);
                wr_en = 1'b0;
        endtask

        task automatic read_strobes(input int n);
                repeat (n) begin
                        @(negedge rd_clk);
                        rd_en = 1'b1;
                end
                @(negedge rd_clk);
                rd_en = 1'b0;
        endtask

        // Runs until n writes were accepted
        task automatic push_words(input int n, input int unsigned pct);
                int target;
                target = push_total + n;
                while (push_total < target) begin
                        @(negedge wr_clk);
                        wr_en = (push_total < target) && ($urandom_range(99) < pct);
                        wr_data = data_t'($urandom);
                end
                wr_en = 1'b0;
        endtask

        task automatic pop_words(input int n, input int unsigned pct);
                int target;
                target = pop_total + n;
                while (pop_total < target) begin
                        @(negedge rd_clk);
                        rd_en = (pop_total < target) && ($urandom_range(99) < pct);
                end
                rd_en = 1'b0;
        endtask

        function automatic int unsigned density();
                int unsigned pick;
                pick = $urandom_range(3);
                case (pick)
                        0:       return 20;
                        1:       return 50;
                        2:       return 80;
                        default: return 95;
                endcase
        endfunction

        // About 100 rd_clk cycles of free traffic in both domains
        task automatic random_burst(input int unsigned wr_pct, input int unsigned rd_pct);
                fork
                        begin
                                repeat (77) begin
                                        @(negedge wr_clk);
                                        wr_en = ($urandom_range(99) < wr_pct);
                                        wr_data = data_t'($urandom);
                                end
                                @(negedge wr_clk);
                                wr_en = 1'b0;
                        end
                        begin
                                repeat (100) begin
                                        @(negedge rd_clk);
                                        rd_en = ($urandom_range(99) < rd_pct);
                                end
                                @(negedge rd_clk);
                                rd_en = 1'b0;
                        end
                join
        endtask

        // ----------------------------------------
        // Phases
        // ----------------------------------------
        initial begin
                void'($urandom(32'h9778_f3cd));
                wr_en    = 1'b0;
                rd_en    = 1'b0;
                wr_data  = '0;
                wr_rst_n = 1'b0;
                rd_rst_n = 1'b0;
                apply_reset();
                settle(8);

                // Fill and then strobes that must be dropped
                write_strobes(fifo_depth + 4);
                settle(8);

                // Drain past empty with extra ignored reads
                read_strobes(fifo_depth + 3);
                settle(8);

                // Streaming through the pointer wrap
                fork
                        push_words(30, 70);
                        pop_words(30, 60);
                join
                settle(8);

                // Levels around the almost-empty threshold
                push_words(3, 100);
                settle(8);
                pop_words(2, 100);
                settle(8);

                // Mixed densities with settle windows
                repeat (15) begin
                        random_burst(density(), density());
                        settle(8);
                end

                // Final drain
                pop_words(model_size, 100);
                read_strobes(3);
                settle(8);

                if (uut.u_chk.err_count != 0) begin
                        fail_run("Assertion failures at end of run");
                end else begin
                        $display("Done: no errors");
                        $finish;
                end
        end

endmodule : fifo_async_tb

`default_nettype wire

//--- tests/fifo_async_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_async_assertions
        import fifo_types_pkg::*, fifo_cfg_pkg::*;
(
        input logic  wr_clk,
        input logic  wr_rst_n,
        input logic  rd_clk,
        input logic  rd_rst_n,
        input logic  rd_en,
        input data_t rd_data,
        input ptr_t  count,
        input logic  wr_full,
        input logic  wr_almost_full,
        input logic  rd_empty,
        input logic  rd_almost_empty,
        // Model side, driven by the testbench
        input data_t model_front,
        input int    model_size,
        input logic  no_write_yet,
        input logic  settled
);

        // Failed checks so far
        int err_count = 0;

        logic in_reset;
        assign in_reset = !wr_rst_n || !rd_rst_n;

        // ----------------------------------------
        // Reset values
        // ----------------------------------------
        a_rst_empty: assert property (@(posedge rd_clk) disable iff (in_reset)
                no_write_yet |-> rd_empty)
                else begin
                        err_count++;
                        $error("Error %0t rd_empty: got %b, expected 1", $time, $sampled(rd_empty));
                end

        a_rst_count: assert property (@(posedge rd_clk) disable iff (in_reset)
                no_write_yet |-> (count == '0))
                else begin
                        err_count++;
                        $error("Error %0t count: got %0d, expected 0", $time, $sampled(count));
                end

        // Either flag high is wrong before the first write
        a_rst_full: assert property (@(posedge wr_clk) disable iff (in_reset)
                no_write_yet |-> !(wr_full || wr_almost_full))
                else begin
                        err_count++;
                        $error("Error %0t wr_full/wr_almost_full: got %b/%b, expected 0/0",
                               $time, $sampled(wr_full), $sampled(wr_almost_full));
                end

        // ----------------------------------------
        // Order and integrity
        // ----------------------------------------

        // Head word retired on an accepted read
        a_head_word: assert property (@(posedge rd_clk) disable iff (in_reset)
                (rd_en && !rd_empty) |-> (rd_data == model_front))
                else begin
                        err_count++;
                        $error("Error %0t rd_data: got %h, expected %h",
                               $time, $sampled(rd_data), $sampled(model_front));
                end

        // ----------------------------------------
        // Full and empty
        // ----------------------------------------

        // Write side view lags reads and so never misses a full ring
        a_full_at_depth: assert property (@(posedge wr_clk) disable iff (in_reset)
                (model_size == fifo_depth) |-> wr_full)
                else begin
                        err_count++;
                        $error("Error %0t wr_full: got %b, expected 1", $time, $sampled(wr_full));
                end

        a_full_almost: assert property (@(posedge wr_clk) disable iff (in_reset)
                wr_full |-> wr_almost_full)
                else begin
                        err_count++;
                        $error("Error %0t wr_almost_full: got %b, expected 1",
                               $time, $sampled(wr_almost_full));
                end

        a_empty_at_zero: assert property (@(posedge rd_clk) disable iff (in_reset)
                (model_size == 0) |-> rd_empty)
                else begin
                        err_count++;
                        $error("Error %0t rd_empty: got %b, expected 1", $time, $sampled(rd_empty));
                end

        // Read strobe on an empty FIFO must not move the read pointer
        a_ignored_read: assert property (@(posedge rd_clk) disable iff (in_reset)
                (rd_en && rd_empty) |=> (int'(count) <= model_size))
                else begin
                        err_count++;
                        $error("Error %0t count: got %0d, expected at most %0d",
                               $time, $sampled(count), $sampled(model_size));
                end

        // ----------------------------------------
        // Settled thresholds
        // ----------------------------------------
        a_settled_count: assert property (@(posedge rd_clk) disable iff (in_reset)
                settled |-> (int'(count) == model_size))
                else begin
                        err_count++;
                        $error("Error %0t count: got %0d, expected %0d",
                               $time, $sampled(count), $sampled(model_size));
                end

        a_settled_almost_empty: assert property (@(posedge rd_clk) disable iff (in_reset)
                (settled && !rd_empty) |-> (rd_almost_empty == (model_size <= almost_empty_thr)))
                else begin
                        err_count++;
                        $error("Error %0t rd_almost_empty: got %b, expected %b", $time,
                               $sampled(rd_almost_empty), $sampled(model_size) <= almost_empty_thr);
                end

        a_settled_almost_full: assert property (@(posedge wr_clk) disable iff (in_reset)
                settled |-> (wr_almost_full == (model_size >= almost_full_thr)))
                else begin
                        err_count++;
                        $error("Error %0t wr_almost_full: got %b, expected %b", $time,
                               $sampled(wr_almost_full), $sampled(model_size) >= almost_full_thr);
                end

endmodule : fifo_async_assertions

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

// Free running clock, starts low
module tb_clk_gen #(
        parameter int period_ns = 100
) (
        output logic clk
);

        initial begin
                clk = 1'b0;
                forever begin
                        #(period_ns / 2);
                        clk = ~clk;
                end
        end

endmodule : tb_clk_gen

`default_nettype wire

//--- logic/fifo_async.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_async
        import fifo_types_pkg::*;
(
        // Write side
        input  logic  wr_clk,
        input  logic  wr_rst_n,
        input  logic  wr_en,
        input  data_t wr_data,
        // Read side
        input  logic  rd_clk,
        input  logic  rd_rst_n,
        input  logic  rd_en,
        output data_t rd_data,
        // Status
        output ptr_t  count,
        output logic  wr_full,
        output logic  wr_almost_full,
        output logic  rd_empty,
        output logic  rd_almost_empty
);

        // Pointer bundle shared by counters, synchronizers and flags
        fifo_ptr_if ptr_bus ();

        // Gray pointers, the only signals that cross domains
        ptr_t wr_ptr_gray;
        ptr_t rd_ptr_gray;

        // Accepted write
        logic wr_push;

        // ----------------------------------------
        // Pointer counters
        // ----------------------------------------
        fifo_wr_ptr u_wr_ptr (
                .wr_clk      (wr_clk),
                .wr_rst_n    (wr_rst_n),
                .wr_en       (wr_en),
                .wr_full     (wr_full),
                .ptr         (ptr_bus.wr_side),
                .wr_ptr_gray (wr_ptr_gray),
                .wr_push     (wr_push)
        );

        fifo_rd_ptr u_rd_ptr (
                .rd_clk      (rd_clk),
                .rd_rst_n    (rd_rst_n),
                .rd_en       (rd_en),
                .rd_empty    (rd_empty),
                .ptr         (ptr_bus.rd_side),
                .rd_ptr_gray (rd_ptr_gray)
        );

        // ----------------------------------------
        // Crossings
        // ----------------------------------------

        // Read pointer into the write domain
        gray_sync u_sync_rd2wr (
                .dst_clk   (wr_clk),
                .dst_rst_n (wr_rst_n),
                .gray_in   (rd_ptr_gray),
                .bin_out   (ptr_bus.wdom_rd_ptr_bin)
        );

        // Write pointer into the read domain
        gray_sync u_sync_wr2rd (
                .dst_clk   (rd_clk),
                .dst_rst_n (rd_rst_n),
                .gray_in   (wr_ptr_gray),
                .bin_out   (ptr_bus.rdom_wr_ptr_bin)
        );

        // Storage, addressed by the low bits of each local pointer
        fifo_mem u_mem (
                .wr_clk  (wr_clk),
                .wr_en   (wr_push),
                .wr_addr (ptr_bus.wr_ptr_bin[addr_w-1:0]),
                .wr_data (wr_data),
                .rd_addr (ptr_bus.rd_ptr_bin[addr_w-1:0]),
                .rd_data (rd_data)
        );

        // Flags and occupancy
        fifo_control u_ctrl (
                .wr_clk          (wr_clk),
                .wr_rst_n        (wr_rst_n),
                .rd_clk          (rd_clk),
                .rd_rst_n        (rd_rst_n),
                .ptr             (ptr_bus.ctrl),
                .count           (count),
                .wr_full         (wr_full),
                .wr_almost_full  (wr_almost_full),
                .rd_empty        (rd_empty),
                .rd_almost_empty (rd_almost_empty)
        );

endmodule : fifo_async

`default_nettype wire

//--- logic/fifo_control.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_control
        import fifo_types_pkg::*, fifo_cfg_pkg::*;
(
        input  logic     wr_clk,
        input  logic     wr_rst_n,
        input  logic     rd_clk,
        input  logic     rd_rst_n,
        fifo_ptr_if.ctrl ptr,
        output ptr_t     count,
        output logic     wr_full,
        output logic     wr_almost_full,
        output logic     rd_empty,
        output logic     rd_almost_empty
);

        // Wrap bit differs between the two pointers of a domain
        logic wdom_xor;
        logic rdom_xor;

        // Address bits equal, ring is either full or empty
        logic wdom_addr_eq;
        logic rdom_addr_eq;

        // Occupancy as each domain sees it
        ptr_t wr_used;
        ptr_t rd_used;

        logic wr_almost_full_d;
        logic rd_almost_empty_d;

        // ----------------------------------------
        // Write domain
        // ----------------------------------------
        assign wdom_xor     = ptr.wr_ptr_bin[addr_w] ^ ptr.wdom_rd_ptr_bin[addr_w];
        assign wdom_addr_eq = (ptr.wr_ptr_bin[addr_w-1:0] == ptr.wdom_rd_ptr_bin[addr_w-1:0]);

        // Same slot, one lap ahead
        // Both pointers are flop outputs, decode is direct so the
        // strobe on the next edge already sees the new state
        assign wr_full = wdom_xor && wdom_addr_eq;

        // Modular difference, the extra bit covers a full ring of 16
        assign wr_used = ptr.wr_ptr_bin - ptr.wdom_rd_ptr_bin;

        assign wr_almost_full_d = (wr_used >= ptr_t'(almost_full_thr));

        // Early warning only, one edge of lag is harmless
        // Occupancy steps up by one per write, so this is set
        // well before wr_full can rise
        always_ff @(posedge wr_clk, negedge wr_rst_n) begin
                if (!wr_rst_n) begin
                        wr_almost_full <= 1'b0;
                end else begin
                        wr_almost_full <= wr_almost_full_d;
                end
        end

        // ----------------------------------------
        // Read domain
        // ----------------------------------------
        assign rdom_xor     = ptr.rd_ptr_bin[addr_w] ^ ptr.rdom_wr_ptr_bin[addr_w];
        assign rdom_addr_eq = (ptr.rd_ptr_bin[addr_w-1:0] == ptr.rdom_wr_ptr_bin[addr_w-1:0]);

        // Same slot, same lap
        assign rd_empty = !rdom_xor && rdom_addr_eq;

        // Pessimistic, write pointer seen here is two edges old
        assign rd_used = ptr.rdom_wr_ptr_bin - ptr.rd_ptr_bin;

        // Read side occupancy
        assign count = rd_used;

        assign rd_almost_empty_d = (rd_used <= ptr_t'(almost_empty_thr));

        always_ff @(posedge rd_clk, negedge rd_rst_n) begin
                if (!rd_rst_n) begin
                        rd_almost_empty <= 1'b0;
                end else begin
                        rd_almost_empty <= rd_almost_empty_d;
                end
        end

endmodule : fifo_control

`default_nettype wire

//--- logic/fifo_mem.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_mem
        import fifo_types_pkg::*, fifo_cfg_pkg::*;
(
        input  logic  wr_clk,
        input  logic  wr_en,
        input  addr_t wr_addr,
        input  data_t wr_data,
        input  addr_t rd_addr,
        output data_t rd_data
);

        // Storage ring
        data_t mem [fifo_depth];

        // Write port in the write clock domain
        // wr_en is already qualified with full upstream
        always_ff @(posedge wr_clk) begin
                if (wr_en) begin
                        mem[wr_addr] <= wr_data;
                end
        end

        // Read port has no clock
        // Head word shows as soon as the read pointer moves,
        // first-word-fall-through behaviour
        assign rd_data = mem[rd_addr];

        // Slot under rd_addr is stable while the read side sees it as
        // valid, since the write side only reuses retired slots

endmodule : fifo_mem

`default_nettype wire

//--- logic/gray_sync.sv
`timescale 1ns/1ns
`default_nettype none

module gray_sync
        import fifo_types_pkg::*;
(
        input  logic dst_clk,
        input  logic dst_rst_n,
        input  ptr_t gray_in,
        output ptr_t bin_out
);

        // First stage may go metastable, never used directly
        ptr_t sync_meta;

        // Settled Gray value in the destination domain
        ptr_t sync_gray;

        // ----------------------------------------
        // Two-flop crossing
        // ----------------------------------------

        // Source is a register and Gray coded, so at most one bit
        // is in flight and the sampled value is old or new
        always_ff @(posedge dst_clk, negedge dst_rst_n) begin
                if (!dst_rst_n) begin
                        sync_meta <= '0;
                        sync_gray <= '0;
                end else begin
                        sync_meta <= gray_in;
                        sync_gray <= sync_meta;
                end
        end

        // ----------------------------------------
        // Gray to binary
        // ----------------------------------------

        // Bit i is the XOR of all Gray bits from i upward
        always_comb begin
                for (int i = 0; i < ptr_w; i++) begin
                        bin_out[i] = ^(sync_gray >> i);
                end
        end

endmodule : gray_sync

`default_nettype wire

//--- logic/fifo_rd_ptr.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_rd_ptr
        import fifo_types_pkg::*;
(
        input  logic        rd_clk,
        input  logic        rd_rst_n,
        input  logic        rd_en,
        input  logic        rd_empty,
        fifo_ptr_if.rd_side ptr,
        output ptr_t        rd_ptr_gray
);

        logic rd_pop;
        ptr_t rd_bin;
        ptr_t rd_bin_next;

        // Read strobe on an empty FIFO has no effect
        assign rd_pop = rd_en && !rd_empty;

        // Retire the head word, next one falls through
        assign rd_bin_next = rd_bin + ptr_t'(rd_pop);

        // Binary and Gray forms move on the same edge
        always_ff @(posedge rd_clk, negedge rd_rst_n) begin
                if (!rd_rst_n) begin
                        rd_bin      <= '0;
                        rd_ptr_gray <= '0;
                end else begin
                        rd_bin      <= rd_bin_next;
                        rd_ptr_gray <= rd_bin_next ^ (rd_bin_next >> 1);
                end
        end

        // Head of the FIFO, also the storage read address
        assign ptr.rd_ptr_bin = rd_bin;

endmodule : fifo_rd_ptr

`default_nettype wire

//--- logic/fifo_wr_ptr.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_wr_ptr
        import fifo_types_pkg::*;
(
        input  logic        wr_clk,
        input  logic        wr_rst_n,
        input  logic        wr_en,
        input  logic        wr_full,
        fifo_ptr_if.wr_side ptr,
        output ptr_t        wr_ptr_gray,
        output logic        wr_push
);

        ptr_t wr_bin;
        ptr_t wr_bin_next;

        // Strobe while full is simply dropped
        assign wr_push = wr_en && !wr_full;

        // Wraps naturally through the extra top bit
        assign wr_bin_next = wr_bin + ptr_t'(wr_push);

        // Gray copy registered alongside the binary count
        // so only one bit moves per write when it crosses
        always_ff @(posedge wr_clk, negedge wr_rst_n) begin
                if (!wr_rst_n) begin
                        wr_bin      <= '0;
                        wr_ptr_gray <= '0;
                end else begin
                        wr_bin      <= wr_bin_next;
                        wr_ptr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
                end
        end

        // Local binary pointer for flags and storage address
        assign ptr.wr_ptr_bin = wr_bin;

endmodule : fifo_wr_ptr

`default_nettype wire

//--- logic/fifo_ptr_if.sv
`timescale 1ns/1ns
`default_nettype none

// Binary pointers as seen by the flag logic
interface fifo_ptr_if
        import fifo_types_pkg::*;
();

        // Write domain view
        ptr_t wr_ptr_bin;
        ptr_t wdom_rd_ptr_bin;

        // Read domain view
        ptr_t rd_ptr_bin;
        ptr_t rdom_wr_ptr_bin;

        // Write clock domain owns its local pointer and the synced read pointer
        modport wr_side (output wr_ptr_bin, output wdom_rd_ptr_bin);

        // Mirror for the read clock domain
        modport rd_side (output rd_ptr_bin, output rdom_wr_ptr_bin);

        // Flag and occupancy logic only looks
        modport ctrl (input wr_ptr_bin, input wdom_rd_ptr_bin,
                      input rd_ptr_bin, input rdom_wr_ptr_bin);

endinterface : fifo_ptr_if

`default_nettype wire

//--- logic/fifo_cfg_pkg.sv
`default_nettype none

// Depth and flag thresholds of the async FIFO
package fifo_cfg_pkg;

        // Power-of-two depth only, follows the address width
        localparam int fifo_depth = 2 ** fifo_types_pkg::addr_w;

        // Entries short of full where the early warning starts
        localparam int almost_wr_margin = 2;

        // Entries above empty where the early warning starts
        localparam int almost_rd_margin = 2;

        // Write side flags almost full at this occupancy or more
        localparam int almost_full_thr = fifo_depth - almost_wr_margin;

        // Read side flags almost empty at this occupancy or less
        localparam int almost_empty_thr = almost_rd_margin;

endpackage : fifo_cfg_pkg

`default_nettype wire

//--- logic/fifo_types_pkg.sv
`default_nettype none

// Widths shared by every block of the async FIFO
package fifo_types_pkg;

        // ----------------------------------------
        // Widths
        // ----------------------------------------

        // Payload word
        localparam int data_w = 8;

        // Storage index, depth is 2**addr_w
        localparam int addr_w = 4;

        // Extra top bit tells a full ring from an empty one
        localparam int ptr_w = addr_w + 1;

        // ----------------------------------------
        // Vector types
        // ----------------------------------------
        typedef logic [data_w-1:0] data_t;
        typedef logic [addr_w-1:0] addr_t;

        // Binary or Gray pointer, same width either way
        typedef logic [ptr_w-1:0] ptr_t;

endpackage : fifo_types_pkg

`default_nettype wire
